// File: all.f
+incdir+hdl
hdl/alu_pkg.sv
hdl/ripple_adder.sv
hdl/barrel_shifter.sv
hdl/booth_multiplier.sv
hdl/restoring_divider.sv
hdl/alu.sv
testbench/alu_checker.sv
testbench/alu_tb.sv

// File: testbench/alu_tb.sv
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_tb;

	logic        clock;
	logic        rst;
	logic        go;
	logic        busy;
	logic        done;
	logic [4:0]  opcode;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] hi;
	logic [31:0] lo;
	logic [63:0] z;
	logic [31:0] rng_state = 32'd43;

	alu DUT (.*);

	alu_checker CHK (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic wait_done(input logic [4:0] op);
		int waited;
		waited = 0;
		@(negedge clock);
		go = 1'b0;
		while (!done && waited < 100) begin
			@(negedge clock);
			waited++;
		end
		if (!done) begin
			$display("timeout: opcode %0d gave no done within 100 cycles", op);
			CHK.print_counts();
			$display("Test failed");
			$finish;
		end
	endtask

	task automatic run_op(input logic [4:0] op, input logic [31:0] x, input logic [31:0] y);
		@(negedge clock);
		go = 1'b1;
		opcode = op;
		a = x;
		b = y;
		wait_done(op);
	endtask

	task automatic sweep_simple(input logic [4:0] op);
		repeat (20) run_op(op, next_random(), next_random());
		run_op(op, 32'hffffffff, 32'h00000001); // sums that carry out
		run_op(op, 32'h80000000, 32'h80000000);
	endtask

	task automatic sweep_shift(input logic [4:0] op);
		logic [31:0] v;
		v = next_random();
		run_op(op, v, 32'd0);
		run_op(op, v, 32'd31);
		run_op(op, 32'h80000001, 32'd31);
		repeat (8) run_op(op, next_random(), next_random());
		repeat (4) run_op(op, next_random() | 32'h80000000, next_random()); // negative values
	endtask

	initial begin
		go = 1'b0;
		opcode = '0;
		a = '0;
		b = '0;
		rst = 1'b1;
		repeat (8) @(negedge clock);
		rst = 1'b0;

		sweep_simple(`ALU_OP_AND);
		sweep_simple(`ALU_OP_OR);
		sweep_simple(`ALU_OP_NOT);
		sweep_simple(`ALU_OP_ADD);
		sweep_simple(`ALU_OP_SUB);
		sweep_simple(`ALU_OP_NEG);
		sweep_shift(`ALU_OP_SHR);
		sweep_shift(`ALU_OP_SHRA);
		sweep_shift(`ALU_OP_SHL);
		sweep_shift(`ALU_OP_ROR);
		sweep_shift(`ALU_OP_ROL);

		// multiply corners, then random pairs
		run_op(`ALU_OP_MUL, 32'h80000000, 32'h80000000);
		run_op(`ALU_OP_MUL, 32'h80000000, 32'hffffffff);
		run_op(`ALU_OP_MUL, 32'hffffffff, 32'hffffffff);
		run_op(`ALU_OP_MUL, 32'h7fffffff, 32'h80000000);
		run_op(`ALU_OP_MUL, 32'hffffffff, next_random());
		run_op(`ALU_OP_MUL, 32'd0, next_random());
		run_op(`ALU_OP_MUL, next_random(), 32'd0);
		repeat (10) run_op(`ALU_OP_MUL, next_random(), next_random());

		// every sign combination, overflow case and zero divisor
		run_op(`ALU_OP_DIV, 32'd100, 32'd7);
		run_op(`ALU_OP_DIV, -32'sd100, 32'd7);
		run_op(`ALU_OP_DIV, 32'd100, -32'sd7);
		run_op(`ALU_OP_DIV, -32'sd100, -32'sd7);
		run_op(`ALU_OP_DIV, 32'd7, 32'd100);
		run_op(`ALU_OP_DIV, 32'h80000000, 32'hffffffff);
		run_op(`ALU_OP_DIV, 32'd5, 32'd0);
		run_op(`ALU_OP_DIV, -32'sd5, 32'd0);
		repeat (10) run_op(`ALU_OP_DIV, next_random(), next_random());
		repeat (10) run_op(`ALU_OP_DIV, next_random(), next_random() >> 20);

		// second go lands while the multiply is busy
		@(negedge clock);
		go = 1'b1;
		opcode = `ALU_OP_MUL;
		a = 32'h12345678;
		b = 32'hfedcba98;
		@(negedge clock);
		opcode = `ALU_OP_ADD;
		a = 32'd1;
		b = 32'd2;
		wait_done(`ALU_OP_MUL);
		repeat (40) @(negedge clock); // room for a stray second done
		run_op(`ALU_OP_ADD, 32'd3, 32'd4);
		run_op(5'd0, next_random(), next_random());
		run_op(5'd12, next_random(), next_random());
		run_op(5'd31, next_random(), next_random());

		repeat (3) @(negedge clock);
		CHK.print_counts();
		if (CHK.fail_count == 0 && !CHK.pending)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: testbench/alu_checker.sv
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_checker (
	input logic        clock,
	input logic        rst,
	input logic        go,
	input logic [4:0]  opcode,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [63:0] z,
	input logic [31:0] hi,
	input logic [31:0] lo,
	input logic        busy,
	input logic        done
);

	int           test_count = 0;
	int           fail_count = 0;
	int           cycle = 0;
	int           go_cycle;
	int           latency;
	logic         pending = 1'b0;   // an accepted op still owes a done
	logic         in_reset = 1'b0;
	logic         bad;
	logic         multi_q;
	logic         busy_gap;         // busy fell before the done of a mul or div
	logic [4:0]   op_q;
	logic [31:0]  a_q;
	logic [31:0]  b_q;
	logic [31:0]  model_hi = '0;
	logic [31:0]  model_lo = '0;
	logic [127:0] want;             // z, hi, lo

	function automatic string op_name(input logic [4:0] op);
		case (op)
			`ALU_OP_AND:  return "and";
			`ALU_OP_OR:   return "or";
			`ALU_OP_ADD:  return "add";
			`ALU_OP_SUB:  return "sub";
			`ALU_OP_MUL:  return "mul";
			`ALU_OP_DIV:  return "div";
			`ALU_OP_SHR:  return "shr";
			`ALU_OP_SHRA: return "shra";
			`ALU_OP_SHL:  return "shl";
			`ALU_OP_ROR:  return "ror";
			`ALU_OP_ROL:  return "rol";
			`ALU_OP_NEG:  return "neg";
			`ALU_OP_NOT:  return "not";
			default:      return "unknown";
		endcase
	endfunction

	// expected {z, hi, lo} where single-cycle ops keep the previous hi and lo
	function automatic logic [127:0] expected_result(input logic [4:0] op,
			input logic [31:0] x, input logic [31:0] y);
		longint      p;
		longint      r;
		logic [31:0] res;
		case (op)
			`ALU_OP_AND:  res = x & y;
			`ALU_OP_OR:   res = x | y;
			`ALU_OP_NOT:  res = ~x;
			`ALU_OP_ADD:  res = x + y;
			`ALU_OP_SUB:  res = x - y;
			`ALU_OP_NEG:  res = -x;
			`ALU_OP_SHR:  res = x >> y[4:0];
			`ALU_OP_SHRA: res = $signed(x) >>> y[4:0];
			`ALU_OP_SHL:  res = x << y[4:0];
			`ALU_OP_ROR:  res = (x >> y[4:0]) | (x << (`ALU_WIDTH - y[4:0]));
			`ALU_OP_ROL:  res = (x << y[4:0]) | (x >> (`ALU_WIDTH - y[4:0]));
			`ALU_OP_MUL: begin
				p = longint'($signed(x)) * longint'($signed(y));
				return {p, p};
			end
			`ALU_OP_DIV: begin
				if (y == '0)
					return {x, 32'hffffffff, x, 32'hffffffff};
				p = longint'($signed(x)) / longint'($signed(y)); // truncates toward zero
				r = longint'($signed(x)) % longint'($signed(y));
				return {r[31:0], p[31:0], r[31:0], p[31:0]};
			end
			default: res = '0;
		endcase
		return {32'd0, res, model_hi, model_lo};
	endfunction

	task automatic compare(input string name, input string what,
			input logic [63:0] expected, input logic [63:0] actual);
		if (actual !== expected) begin
			$display("mismatch test %0d %s %s: expected %h actual %h",
				test_count, name, what, expected, actual);
			bad = 1'b1;
		end
	endtask

	task automatic end_test(input string name);
		if (bad) begin
			fail_count++;
			$display("test %0d %s: error", test_count, name);
		end else begin
			$display("test %0d %s: ok", test_count, name);
		end
	endtask

	task automatic print_counts();
		$display("%0d tests, %0d passed, %0d failed",
			test_count, test_count - fail_count, fail_count);
	endtask

	// everything read here is the value from before this edge
	always @(posedge clock) begin
		cycle++;
		if (rst) begin
			pending = 1'b0;
			in_reset = 1'b1;
			model_hi = '0;
			model_lo = '0;
		end else begin
			if (in_reset) begin // first edge out of reset
				in_reset = 1'b0;
				test_count++;
				bad = 1'b0;
				compare("reset", "z", '0, z);
				compare("reset", "hi", '0, hi);
				compare("reset", "lo", '0, lo);
				compare("reset", "busy", '0, busy);
				compare("reset", "done", '0, done);
				end_test("reset");
			end
			if (done && !pending) begin
				$display("done pulsed with no operation in progress");
				fail_count++;
			end else if (done) begin
				pending = 1'b0;
				test_count++;
				bad = 1'b0;
				want = expected_result(op_q, a_q, b_q);
				compare(op_name(op_q), "z", want[127:64], z);
				compare(op_name(op_q), "hi", want[63:32], hi);
				compare(op_name(op_q), "lo", want[31:0], lo);
				// edge that raised done, counted from the accept edge
				latency = cycle - 1 - go_cycle;
				if (latency != (multi_q ? 33 : 0)) begin
					$display("mismatch test %0d %s latency: expected %0d actual %0d",
						test_count, op_name(op_q), multi_q ? 33 : 0, latency);
					bad = 1'b1;
				end
				if (busy || busy_gap) begin
					$display("test %0d %s: busy did not cover exactly the operation",
						test_count, op_name(op_q));
					bad = 1'b1;
				end
				model_hi = want[63:32];
				model_lo = want[31:0];
				end_test(op_name(op_q));
			end else if (pending && multi_q && !busy) begin
				busy_gap = 1'b1;
			end
			if (go && !busy) begin // go is dropped while busy
				op_q = opcode;
				a_q = a;
				b_q = b;
				multi_q = (opcode == `ALU_OP_MUL) || (opcode == `ALU_OP_DIV);
				busy_gap = 1'b0;
				go_cycle = cycle;
				pending = 1'b1;
			end
		end
	end

endmodule

// File: hdl/alu.sv
`timescale 1ns/10ps
`include "alu_params.svh"

module alu
	import alu_pkg::*;
(
	input  logic                    clock,
	input  logic                    rst,
	input  logic                    go,
	input  alu_opcode_t             opcode,
	input  logic [`ALU_WIDTH-1:0]   a,
	input  logic [`ALU_WIDTH-1:0]   b,
	output logic [2*`ALU_WIDTH-1:0] z,
	output logic [`ALU_WIDTH-1:0]   hi,
	output logic [`ALU_WIDTH-1:0]   lo,
	output logic                    busy,
	output logic                    done
);

	logic                  accept;
	logic                  is_neg;
	logic                  is_multi;
	logic [`ALU_WIDTH-1:0] add_result;
	logic [`ALU_WIDTH-1:0] shift_result;
	logic [`ALU_WIDTH-1:0] single_result;
	logic                  mul_busy, mul_done;
	logic                  div_busy, div_done;
	alu_wide_t             mul_product;
	alu_wide_t             div_result;

	// held until the result of a mul or div has been copied
	assign busy = mul_busy | div_busy | mul_done | div_done;
	assign accept = go & ~busy;
	assign is_neg = (opcode == `ALU_OP_NEG);
	assign is_multi = (opcode == `ALU_OP_MUL) || (opcode == `ALU_OP_DIV);

	// negate is 0 - a
	ripple_adder u_adder (
		.a   (is_neg ? '0 : a),
		.b   (is_neg ? a : b),
		.sub ((opcode == `ALU_OP_SUB) || is_neg),
		.sum (add_result)
	);

	barrel_shifter u_shifter (
		.value  (a),
		.amount (b[4:0]),
		.right  ((opcode == `ALU_OP_SHR) || (opcode == `ALU_OP_SHRA) || (opcode == `ALU_OP_ROR)),
		.arith  (opcode == `ALU_OP_SHRA),
		.rotate ((opcode == `ALU_OP_ROR) || (opcode == `ALU_OP_ROL)),
		.result (shift_result)
	);

	booth_multiplier u_mul (
		.clock        (clock),
		.rst          (rst),
		.start        (accept && (opcode == `ALU_OP_MUL)),
		.multiplicand (a),
		.multiplier   (b),
		.busy         (mul_busy),
		.done         (mul_done),
		.product      (mul_product)
	);

	restoring_divider u_div (
		.clock    (clock),
		.rst      (rst),
		.start    (accept && (opcode == `ALU_OP_DIV)),
		.dividend (a),
		.divisor  (b),
		.busy     (div_busy),
		.done     (div_done),
		.result   (div_result)
	);

	always_comb begin
		case (opcode)
			`ALU_OP_AND: single_result = a & b;
			`ALU_OP_OR: single_result = a | b;
			`ALU_OP_NOT: single_result = ~a;
			`ALU_OP_ADD, `ALU_OP_SUB, `ALU_OP_NEG: single_result = add_result;
			`ALU_OP_SHR, `ALU_OP_SHRA, `ALU_OP_SHL,
			`ALU_OP_ROR, `ALU_OP_ROL: single_result = shift_result;
			default: single_result = '0; // unknown opcode gives zero
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			z    <= '0;
			hi   <= '0;
			lo   <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (mul_done) begin
				z    <= mul_product;
				hi   <= mul_product.prod.hi;
				lo   <= mul_product.prod.lo;
				done <= 1'b1;
			end else if (div_done) begin
				z    <= div_result;
				hi   <= div_result.quot.remainder;
				lo   <= div_result.quot.quotient;
				done <= 1'b1;
			end else if (accept && !is_multi) begin
				z    <= {{`ALU_WIDTH{1'b0}}, single_result}; // hi and lo untouched
				done <= 1'b1;
			end
		end
	end

endmodule

// File: hdl/restoring_divider.sv
`timescale 1ns/10ps
`include "alu_params.svh"

module restoring_divider
	import alu_pkg::*;
(
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  start,
	input  logic [`ALU_WIDTH-1:0] dividend,
	input  logic [`ALU_WIDTH-1:0] divisor,
	output logic                  busy,
	output logic                  done,
	output alu_wide_t             result
);

	localparam int W = `ALU_WIDTH;

	logic [W-1:0] rem;
	logic [W-1:0] quo;         // dividend magnitude shifts out, quotient bits shift in
	logic [W-1:0] dvs;         // divisor magnitude
	logic [W-1:0] dividend_q;
	logic         neg_q;
	logic         neg_r;
	logic         div_zero;
	logic [W:0]   shifted;
	logic [W:0]   diff;
	logic [4:0]   step;

	assign shifted = {rem, quo[W-1]};

	ripple_adder #(.WIDTH(W + 1)) u_trial (
		.a   (shifted),
		.b   ({1'b0, dvs}),
		.sub (1'b1),
		.sum (diff)
	);

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= '0;
		end else begin
			done <= 1'b0;
			if (start && !busy) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				step <= step + 5'd1;
				if (step == 5'd31) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start && !busy) begin
			rem        <= '0;
			quo        <= dividend[W-1] ? -dividend : dividend;
			dvs        <= divisor[W-1] ? -divisor : divisor;
			dividend_q <= dividend;
			neg_q      <= dividend[W-1] ^ divisor[W-1];
			neg_r      <= dividend[W-1]; // remainder follows the dividend
			div_zero   <= (divisor == '0);
		end else if (busy) begin
			if (diff[W]) begin // negative, keep the old remainder
				rem <= shifted[W-1:0];
				quo <= {quo[W-2:0], 1'b0};
			end else begin
				rem <= diff[W-1:0];
				quo <= {quo[W-2:0], 1'b1};
			end
		end
	end

	always_comb begin
		if (div_zero) begin
			result.quot.remainder = dividend_q;
			result.quot.quotient  = '1;
		end else begin
			result.quot.remainder = neg_r ? -rem : rem;
			result.quot.quotient  = neg_q ? -quo : quo;
		end
	end

endmodule

// File: hdl/booth_multiplier.sv
`timescale 1ns/10ps
`include "alu_params.svh"

module booth_multiplier
	import alu_pkg::*;
(
	input  logic                  clock,
	input  logic                  rst,
	input  logic                  start,
	input  logic [`ALU_WIDTH-1:0] multiplicand,
	input  logic [`ALU_WIDTH-1:0] multiplier,
	output logic                  busy,
	output logic                  done,
	output alu_wide_t             product
);

	localparam int W = `ALU_WIDTH;

	// one guard bit so that adding or subtracting -2^31 cannot overflow
	logic [W:0] acc;
	logic [W:0] mcand;
	logic [W:0] acc_sum;
	logic [W:0] acc_next;
	logic [W:0] mq;    // multiplier, extra low bit below it
	logic [1:0] pair;
	logic [4:0] step;

	assign pair = mq[1:0];

	ripple_adder #(.WIDTH(W + 1)) u_add (
		.a   (acc),
		.b   (mcand),
		.sub (pair == 2'b10),
		.sum (acc_sum)
	);

	// 00 and 11 keep the accumulator
	assign acc_next = (pair[1] ^ pair[0]) ? acc_sum : acc;

	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= '0;
		end else begin
			done <= 1'b0;
			if (start && !busy) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				step <= step + 5'd1;
				if (step == 5'd31) begin // last step
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start && !busy) begin
			acc   <= '0;
			mq    <= {multiplier, 1'b0};
			mcand <= {multiplicand[W-1], multiplicand};
		end else if (busy) begin
			// arithmetic shift right of {acc, mq}
			acc <= {acc_next[W], acc_next[W:1]};
			mq  <= {acc_next[0], mq[W:1]};
		end
	end

	always_comb begin
		product.prod.hi = acc[W-1:0];
		product.prod.lo = mq[W:1];
	end

endmodule

// File: hdl/barrel_shifter.sv
`timescale 1ns/10ps
`include "alu_params.svh"

module barrel_shifter (
	input  logic [`ALU_WIDTH-1:0] value,
	input  logic [4:0]            amount,
	input  logic                  right,
	input  logic                  arith,
	input  logic                  rotate,
	output logic [`ALU_WIDTH-1:0] result
);

	logic [`ALU_WIDTH-1:0] stage [0:5];
	logic                  sign_fill;

	function automatic logic [`ALU_WIDTH-1:0] reverse_bits(input logic [`ALU_WIDTH-1:0] v);
		logic [`ALU_WIDTH-1:0] r;
		for (int i = 0; i < `ALU_WIDTH; i++) begin
			r[i] = v[`ALU_WIDTH-1-i];
		end
		return r;
	endfunction

	// left ops run through the right-shift stages on the mirrored word
	assign stage[0] = right ? value : reverse_bits(value);

	assign sign_fill = arith & right & value[`ALU_WIDTH-1];

	// stage k shifts by 16 >> k under amount bit 4-k
	for (genvar k = 0; k < 5; k++) begin : g_stage
		localparam int SHIFT = (`ALU_WIDTH / 2) >> k;

		logic [SHIFT-1:0] fill;

		// wrapped bits, sign copies or zeros
		assign fill = rotate ? stage[k][SHIFT-1:0] : {SHIFT{sign_fill}};

		assign stage[k+1] = amount[4-k] ? {fill, stage[k][`ALU_WIDTH-1:SHIFT]} : stage[k];
	end

	assign result = right ? stage[5] : reverse_bits(stage[5]);

endmodule

// File: hdl/ripple_adder.sv
`timescale 1ns/10ps
`include "alu_params.svh"

module ripple_adder #(
	parameter int WIDTH = `ALU_WIDTH
) (
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	input  logic             sub,
	output logic [WIDTH-1:0] sum
);

	logic [WIDTH-1:0] b_eff;
	logic [WIDTH-1:0] carry;

	// a - b is a + ~b + 1
	assign b_eff = b ^ {WIDTH{sub}};
	assign carry[0] = sub;

	for (genvar i = 0; i < WIDTH; i++) begin : g_cell
		assign sum[i] = a[i] ^ b_eff[i] ^ carry[i];

		// carry out of the top cell is not needed
		if (i < WIDTH - 1) begin : g_carry
			assign carry[i+1] = (a[i] & b_eff[i]) | (carry[i] & (a[i] ^ b_eff[i]));
		end
	end

endmodule

// File: hdl/alu_pkg.sv
`include "alu_params.svh"

package alu_pkg;

	typedef logic [4:0] alu_opcode_t;

	// upper and lower words of a signed product
	typedef struct packed {
		logic [`ALU_WIDTH-1:0] hi;
		logic [`ALU_WIDTH-1:0] lo;
	} alu_product_t;

	typedef struct packed {
		logic [`ALU_WIDTH-1:0] remainder; // upper word, lands in hi
		logic [`ALU_WIDTH-1:0] quotient;
	} alu_quotient_t;

	// one 64-bit word, read as product or as quotient/remainder
	typedef union packed {
		alu_product_t  prod;
		alu_quotient_t quot;
	} alu_wide_t;

endpackage

// File: hdl/alu_params.svh
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// datapath width of the operands
`define ALU_WIDTH 32

// opcode encoding of the datapath control unit
`define ALU_OP_ADD  5'd3
`define ALU_OP_SUB  5'd4
`define ALU_OP_AND  5'd5
`define ALU_OP_OR   5'd6
`define ALU_OP_ROR  5'd7
`define ALU_OP_ROL  5'd8
`define ALU_OP_SHR  5'd9
`define ALU_OP_SHRA 5'd10
`define ALU_OP_SHL  5'd11

// multi-cycle ops
`define ALU_OP_DIV  5'd15
`define ALU_OP_MUL  5'd16

// unary ops, both work on a only
`define ALU_OP_NEG  5'd17
`define ALU_OP_NOT  5'd18

`endif
